// ==== src/fetch_pkg.sv ====
package fetch_pkg;

  // byte address and instruction word
  typedef logic [31:0] addr_t;
  typedef logic [31:0] inst_t;

  // one row of an instruction bank
  typedef logic [63:0] dword_t;

  typedef logic [31:0] count_t;

  // doubleword read request from the fetch unit
  typedef struct packed {
    logic  valid;
    addr_t addr;
  } fetch_req_t;

  // read data returned by a bank
  typedef struct packed {
    logic   valid;
    dword_t data;
  } fetch_rsp_t;

  // program load, one 32-bit word per request
  typedef struct packed {
    logic  valid;
    addr_t addr;
    inst_t data;
  } load_req_t;

  // where the current fetch spends its time
  typedef enum logic [1:0] {
    perf_idle,
    perf_wait_mem,
    perf_wait_down
  } perf_state_t;

  // ebreak stops the core
  localparam inst_t EBREAK_INST = 32'h0010_0073;

endpackage

// ==== src/ifu.sv ====
`timescale 1ns/1ps

module ifu
  import fetch_pkg::*;
#(
  parameter addr_t RESET_PC = 32'h8000_0000
) (
  input  logic       clk,
  input  logic       rstn,
  input  addr_t      npc,
  input  logic       inst_ready,
  output logic       inst_valid,
  output inst_t      inst,
  output addr_t      pc,
  output logic       halt,
  output fetch_req_t req,
  input  logic       arready,
  input  fetch_rsp_t rsp,
  output logic       rready
);

  typedef enum logic {
    ifu_issue,
    ifu_wait
  } ifu_state_t;

  ifu_state_t state;
  logic       run;
  addr_t      fetch_addr;
  logic       req_fire;
  logic       down_fire;

  // request goes out from the first cycle after reset release
  assign req.valid = run && (state == ifu_issue);
  assign req.addr  = fetch_addr;
  assign req_fire  = req.valid && arready;

  // bank holds its data until the downstream stage takes it
  assign inst_valid = rsp.valid;
  assign rready     = inst_ready;
  assign down_fire  = inst_valid && inst_ready;

  // pick the 32-bit half by address bit 2
  assign inst = pc[2] ? rsp.data[63:32] : rsp.data[31:0];

  assign halt = down_fire && (inst == EBREAK_INST);

  always_ff @(posedge clk) begin
    if (!rstn) begin
      state      <= ifu_issue;
      run        <= 1'b0;
      fetch_addr <= RESET_PC;
      pc         <= RESET_PC;
    end else begin
      run <= 1'b1;
      case (state)
        ifu_issue: begin
          // address accepted, it becomes the pc in flight
          if (req_fire) begin
            state <= ifu_wait;
            pc    <= fetch_addr;
          end
        end
        ifu_wait: begin
          // execute stage supplies the next address
          if (down_fire) begin
            state      <= ifu_issue;
            fetch_addr <= npc;
          end
        end
        default: begin
          state <= ifu_issue;
        end
      endcase
    end
  end

  // stalled instruction and its pc must not move
  a_inst_hold: assert property (
    @(posedge clk) disable iff (!rstn)
    inst_valid && !inst_ready |=> inst_valid && $stable(inst) && $stable(pc)
  ) else $error("inst changed under back-pressure");

  // one fetch in flight, so data only shows up while waiting
  a_rsp_in_wait: assert property (
    @(posedge clk) disable iff (!rstn)
    rsp.valid |-> state == ifu_wait
  ) else $error("response without an outstanding fetch");

endmodule

// ==== src/bank_router.sv ====
`timescale 1ns/1ps

module bank_router
  import fetch_pkg::*;
#(
  parameter int NUM_BANKS  = 2,
  parameter int BANK_DEPTH = 64
) (
  input  fetch_req_t                    req,
  output logic                          arready,
  input  load_req_t                     load,
  output logic [NUM_BANKS-1:0]          bank_rd,
  input  logic [NUM_BANKS-1:0]          bank_ready,
  output logic [$clog2(BANK_DEPTH)-1:0] bank_row,
  output logic [NUM_BANKS-1:0]          bank_wr,
  output inst_t                         wr_data,
  output logic                          wr_hi
);

  // at least two banks, both counts powers of two
  localparam int BANK_W = $clog2(NUM_BANKS);
  localparam int ROW_W  = $clog2(BANK_DEPTH);

  logic [BANK_W-1:0] rd_bank;
  logic [BANK_W-1:0] ld_bank;
  logic [ROW_W-1:0]  rd_row;
  logic [ROW_W-1:0]  ld_row;

  // bits [2:0] pick the byte inside a doubleword
  assign rd_bank = req.addr[3 +: BANK_W];
  assign ld_bank = load.addr[3 +: BANK_W];
  assign rd_row  = req.addr[3 + BANK_W +: ROW_W];
  assign ld_row  = load.addr[3 + BANK_W +: ROW_W];

  // one row bus for all banks, so a load holds reads off
  always_comb begin
    bank_rd = '0;
    bank_wr = '0;
    if (load.valid) begin
      bank_wr[ld_bank] = 1'b1;
    end else if (req.valid) begin
      bank_rd[rd_bank] = 1'b1;
    end
  end

  assign arready  = !load.valid && bank_ready[rd_bank];
  assign bank_row = load.valid ? ld_row : rd_row;

  assign wr_data = load.data;
  assign wr_hi   = load.addr[2];

  always_comb begin
    a_rd_onehot: assert final ($onehot0(bank_rd))
      else $error("more than one bank read at once");
  end

endmodule

// ==== src/imem_bank.sv ====
`timescale 1ns/1ps

module imem_bank
  import fetch_pkg::*;
#(
  parameter int BANK_DEPTH = 64
) (
  input  logic                          clk,
  input  logic                          rstn,
  input  logic                          rd,
  input  logic                          wr,
  input  logic                          wr_hi,
  input  logic [$clog2(BANK_DEPTH)-1:0] row,
  input  inst_t                         wr_data,
  output logic                          ready,
  output fetch_rsp_t                    rsp,
  input  logic                          rready
);

  dword_t mem [BANK_DEPTH];
  dword_t rsp_data;
  logic   rsp_valid;
  logic   rd_fire;

  // one response at a time
  assign ready   = !rsp_valid;
  assign rd_fire = rd && ready;

  assign rsp.valid = rsp_valid;
  assign rsp.data  = rsp_data;

  // loads fill one half of a row
  always_ff @(posedge clk) begin
    if (wr) begin
      if (wr_hi) begin
        mem[row][63:32] <= wr_data;
      end else begin
        mem[row][31:0] <= wr_data;
      end
    end
    if (rd_fire) begin
      rsp_data <= mem[row];
    end
  end

  // data stays put until the consumer takes it
  always_ff @(posedge clk) begin
    if (!rstn) begin
      rsp_valid <= 1'b0;
    end else if (rd_fire) begin
      rsp_valid <= 1'b1;
    end else if (rready) begin
      rsp_valid <= 1'b0;
    end
  end

  a_rsp_after_read: assert property (
    @(posedge clk) disable iff (!rstn)
    $rose(rsp_valid) |-> $past(rd_fire)
  ) else $error("bank response without an accepted read");

endmodule

// ==== src/resp_merge.sv ====
`timescale 1ns/1ps

module resp_merge
  import fetch_pkg::*;
#(
  parameter int NUM_BANKS = 2
) (
  input  logic                         clk,
  input  logic                         rstn,
  input  logic                         issue,
  input  logic [$clog2(NUM_BANKS)-1:0] issue_bank,
  input  fetch_rsp_t                   bank_rsp [NUM_BANKS],
  output fetch_rsp_t                   rsp
);

  localparam int BANK_W = $clog2(NUM_BANKS);

  logic [BANK_W-1:0] sel_bank;

  // bank of the fetch in flight
  always_ff @(posedge clk) begin
    if (!rstn) begin
      sel_bank <= '0;
    end else if (issue) begin
      sel_bank <= issue_bank;
    end
  end

  // sel_bank is steady until the next issue, so a stalled
  // response keeps coming from the same bank
  assign rsp = bank_rsp[sel_bank];

  for (genvar i = 0; i < NUM_BANKS; i++) begin : g_src_chk
    a_rsp_src: assert property (
      @(posedge clk) disable iff (!rstn)
      bank_rsp[i].valid |-> sel_bank == BANK_W'(i)
    ) else $error("response from bank %0d, expected bank %0d", i, sel_bank);
  end

endmodule

// ==== src/fetch_perf.sv ====
`timescale 1ns/1ps

module fetch_perf
  import fetch_pkg::*;
(
  input  logic   clk,
  input  logic   rstn,
  input  logic   req_fire,
  input  logic   inst_valid,
  input  logic   inst_ready,
  output count_t fetch_count,
  output count_t wait_mem_cycles,
  output count_t wait_down_cycles
);

  perf_state_t state;
  logic        down_fire;
  logic        mem_wait;
  logic        down_wait;

  assign down_fire = inst_valid && inst_ready;

  // one cycle per fetch, the bank answers right after the request
  assign mem_wait  = (state == perf_wait_mem);
  // data is there but not taken, first stall cycle included
  assign down_wait = (state != perf_idle) && inst_valid && !inst_ready;

  always_ff @(posedge clk) begin
    if (!rstn) begin
      state <= perf_idle;
    end else begin
      case (state)
        perf_idle: begin
          if (req_fire) begin
            state <= perf_wait_mem;
          end
        end
        perf_wait_mem: begin
          if (down_fire) begin
            state <= perf_idle;
          end else if (inst_valid) begin
            state <= perf_wait_down;
          end
        end
        perf_wait_down: begin
          if (down_fire) begin
            state <= perf_idle;
          end
        end
        default: begin
          state <= perf_idle;
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (!rstn) begin
      fetch_count      <= '0;
      wait_mem_cycles  <= '0;
      wait_down_cycles <= '0;
    end else begin
      if (down_fire) begin
        fetch_count <= fetch_count + 1'b1;
      end
      if (mem_wait) begin
        wait_mem_cycles <= wait_mem_cycles + 1'b1;
      end
      if (down_wait) begin
        wait_down_cycles <= wait_down_cycles + 1'b1;
      end
    end
  end

endmodule

// ==== src/fetch_top.sv ====
`timescale 1ns/1ps

module fetch_top
  import fetch_pkg::*;
#(
  parameter int    NUM_BANKS  = 2,
  parameter int    BANK_DEPTH = 64,
  parameter addr_t RESET_PC   = 32'h8000_0000
) (
  input  logic      clk,
  input  logic      rstn,
  input  addr_t     npc,
  input  logic      inst_ready,
  input  load_req_t load,
  output logic      inst_valid,
  output inst_t     inst,
  output addr_t     pc,
  output logic      halt,
  output count_t    fetch_count,
  output count_t    wait_mem_cycles,
  output count_t    wait_down_cycles
);

  localparam int BANK_W = $clog2(NUM_BANKS);
  localparam int ROW_W  = $clog2(BANK_DEPTH);

  fetch_req_t         ifu_req;
  fetch_rsp_t         ifu_rsp;
  logic               arready;
  logic               rready;
  logic               req_fire;
  logic [BANK_W-1:0]  issue_bank;
  logic [NUM_BANKS-1:0] bank_rd;
  logic [NUM_BANKS-1:0] bank_ready;
  logic [NUM_BANKS-1:0] bank_wr;
  logic [ROW_W-1:0]   bank_row;
  inst_t              wr_data;
  logic               wr_hi;
  fetch_rsp_t         bank_rsp [NUM_BANKS];

  assign req_fire   = ifu_req.valid && arready;
  assign issue_bank = ifu_req.addr[3 +: BANK_W];

  ifu #(
    .RESET_PC(RESET_PC)
  ) u_ifu (
    .clk       (clk),
    .rstn      (rstn),
    .npc       (npc),
    .inst_ready(inst_ready),
    .inst_valid(inst_valid),
    .inst      (inst),
    .pc        (pc),
    .halt      (halt),
    .req       (ifu_req),
    .arready   (arready),
    .rsp       (ifu_rsp),
    .rready    (rready)
  );

  bank_router #(
    .NUM_BANKS (NUM_BANKS),
    .BANK_DEPTH(BANK_DEPTH)
  ) u_router (
    .req       (ifu_req),
    .arready   (arready),
    .load      (load),
    .bank_rd   (bank_rd),
    .bank_ready(bank_ready),
    .bank_row  (bank_row),
    .bank_wr   (bank_wr),
    .wr_data   (wr_data),
    .wr_hi     (wr_hi)
  );

  // rready goes to every bank, only the one holding data reacts
  for (genvar b = 0; b < NUM_BANKS; b++) begin : g_bank
    imem_bank #(
      .BANK_DEPTH(BANK_DEPTH)
    ) u_bank (
      .clk    (clk),
      .rstn   (rstn),
      .rd     (bank_rd[b]),
      .wr     (bank_wr[b]),
      .wr_hi  (wr_hi),
      .row    (bank_row),
      .wr_data(wr_data),
      .ready  (bank_ready[b]),
      .rsp    (bank_rsp[b]),
      .rready (rready)
    );
  end

  resp_merge #(
    .NUM_BANKS(NUM_BANKS)
  ) u_merge (
    .clk       (clk),
    .rstn      (rstn),
    .issue     (req_fire),
    .issue_bank(issue_bank),
    .bank_rsp  (bank_rsp),
    .rsp       (ifu_rsp)
  );

  fetch_perf u_perf (
    .clk             (clk),
    .rstn            (rstn),
    .req_fire        (req_fire),
    .inst_valid      (inst_valid),
    .inst_ready      (inst_ready),
    .fetch_count     (fetch_count),
    .wait_mem_cycles (wait_mem_cycles),
    .wait_down_cycles(wait_down_cycles)
  );

endmodule

// ==== verif/tb_fetch.sv ====
`timescale 1ns/1ps

module tb_fetch
  import fetch_pkg::*;
();

  localparam int    NUM_BANKS    = 2;
  localparam int    BANK_DEPTH   = 64;
  localparam addr_t RESET_PC     = 32'h8000_0000;
  localparam int    WORDS        = NUM_BANKS * BANK_DEPTH * 2;
  localparam int    IDX_W        = $clog2(WORDS);
  localparam int    RESET_CYCLES = 10;
  localparam inst_t EBREAK       = 32'h0010_0073;
  localparam int    EBREAK_IDX   = 77;
  localparam addr_t EBREAK_ADDR  = RESET_PC + addr_t'(EBREAK_IDX * 4);
  localparam int    SEQ_N        = WORDS - 1;
  localparam int    JUMP_N       = 100;
  localparam int    STALL_N      = 120;
  localparam int    HALT_N       = 40;
  localparam int    TOTAL_N      = 1 + SEQ_N + JUMP_N + STALL_N + HALT_N;
  localparam int    TIMEOUT_CYC  = TOTAL_N * 20 + WORDS + RESET_CYCLES + 50;
  localparam int    M_IDLE       = 0;
  localparam int    M_SEQ        = 1;
  localparam int    M_JUMP       = 2;
  localparam int    M_STALL      = 3;
  localparam int    M_HALT       = 4;

  logic        clk = 1'b0;
  logic        rstn;
  addr_t       npc = RESET_PC + 32'd4;
  logic        inst_ready = 1'b0;
  load_req_t   load;
  logic        inst_valid;
  inst_t       inst;
  addr_t       pc;
  logic        halt;
  count_t      fetch_count;
  count_t      wait_mem_cycles;
  count_t      wait_down_cycles;

  logic [31:0] rng = 32'd96;
  inst_t       ref_mem [WORDS];
  int          mode = M_IDLE;
  int          hs_count = 0;
  int          served = 0;
  int          stall_count = 0;
  int          mem_count = 0;
  int          halt_expected = 0;
  int          halt_seen = 0;
  int          chk_err = 0;
  int          main_err = 0;
  int          failed_tests = 0;
  addr_t       exp_pc = RESET_PC;
  logic        held = 1'b0;
  logic        was_valid = 1'b0;
  inst_t       held_inst;
  addr_t       held_pc;
  int          mark;
  int          base;

  always #20 clk = ~clk;

  fetch_top #(
    .NUM_BANKS (NUM_BANKS),
    .BANK_DEPTH(BANK_DEPTH),
    .RESET_PC  (RESET_PC)
  ) DUT (
    .clk             (clk),
    .rstn            (rstn),
    .npc             (npc),
    .inst_ready      (inst_ready),
    .load            (load),
    .inst_valid      (inst_valid),
    .inst            (inst),
    .pc              (pc),
    .halt            (halt),
    .fetch_count     (fetch_count),
    .wait_mem_cycles (wait_mem_cycles),
    .wait_down_cycles(wait_down_cycles)
  );

  function automatic logic [31:0] lcg_draw();
    rng = rng * 32'd1664525 + 32'd1013904223;
    return rng;
  endfunction

  // rows wrap modulo the bank depth, so the model wraps too
  function automatic inst_t expected_inst(input addr_t a);
    return ref_mem[a[2 +: IDX_W]];
  endfunction

  function automatic addr_t pick_npc(input addr_t cur);
    logic [31:0] r;
    addr_t       jump;
    r    = lcg_draw();
    jump = RESET_PC + addr_t'({r[16 +: IDX_W], 2'b00});
    case (mode)
      M_JUMP:  return jump;
      M_STALL: return r[31] ? cur + 32'd4 : jump;
      M_HALT:  return r[31] ? EBREAK_ADDR : jump;
      default: return cur + 32'd4;
    endcase
  endfunction

  task automatic flag_error(input string msg);
    $display("[ERROR] %0t: %s", $time, msg);
    chk_err++;
  endtask

  task automatic fill_program();
    logic [31:0] r;
    for (int i = 0; i < WORDS; i++) begin
      r = lcg_draw();
      // only one ebreak in the program
      if (r == EBREAK) r = r ^ 32'h1;
      ref_mem[i] = r;
    end
    ref_mem[EBREAK_IDX] = EBREAK;
  endtask

  task automatic load_program();
    for (int i = 0; i < WORDS; i++) begin
      @(posedge clk);
      load <= '{valid: 1'b1, addr: RESET_PC + addr_t'(i * 4), data: ref_mem[i]};
    end
    @(posedge clk);
    load <= '0;
    @(negedge clk);
  endtask

  task automatic drive_fetches(input int sel, input int n);
    int target;
    target = hs_count + n;
    mode   = sel;
    wait (hs_count >= target);
  endtask

  task automatic report_test(input string name, input int n, input int start);
    int errs;
    errs = chk_err + main_err - start;
    if (errs != 0) failed_tests++;
    $display("test %s: %0d fetches, %0d errors, %s", name, n, errs,
             (errs == 0) ? "ok" : "failed");
  endtask

  // npc changes only after the handshake that used it
  always @(posedge clk) begin : drive_proc
    logic [31:0] r;
    if (hs_count != served) begin
      served = hs_count;
      npc <= pick_npc(npc);
    end
    r = lcg_draw();
    case (mode)
      M_SEQ, M_JUMP:   inst_ready <= 1'b1;
      M_STALL, M_HALT: inst_ready <= r[27];
      default:         inst_ready <= 1'b0;
    endcase
  end

  // sampled mid-cycle, inputs and outputs are settled
  always @(negedge clk) begin : compare_proc
    inst_t want;
    if (rstn) begin
      if (held) begin
        assert (inst_valid && inst == held_inst && pc == held_pc)
          else flag_error($sformatf("stalled output moved to inst %h pc %h", inst, pc));
      end
      if (inst_valid && inst_ready) begin
        want = expected_inst(exp_pc);
        assert (pc == exp_pc)
          else flag_error($sformatf("pc %h, expected %h", pc, exp_pc));
        assert (inst == want)
          else flag_error($sformatf("inst %h at pc %h, expected %h", inst, pc, want));
        assert (halt == (want == EBREAK))
          else flag_error($sformatf("halt %b at pc %h", halt, pc));
        assert (fetch_count == count_t'(hs_count))
          else flag_error($sformatf("fetch_count %0d, expected %0d", fetch_count, hs_count));
        assert (wait_down_cycles == count_t'(stall_count))
          else flag_error($sformatf("wait_down_cycles %0d, expected %0d",
                                    wait_down_cycles, stall_count));
        assert (wait_mem_cycles == count_t'(mem_count))
          else flag_error($sformatf("wait_mem_cycles %0d, expected %0d",
                                    wait_mem_cycles, mem_count));
        if (want == EBREAK) halt_expected++;
        if (halt) halt_seen++;
        exp_pc = npc;
        hs_count++;
      end else begin
        assert (!halt) else flag_error("halt high outside an ebreak handshake");
      end
      held = inst_valid && !inst_ready;
      if (held) begin
        stall_count++;
        held_inst = inst;
        held_pc   = pc;
      end
      // first cycle of each response is the memory wait
      if (inst_valid && !was_valid) begin
        mem_count++;
      end
      was_valid = inst_valid;
    end
  end

  initial begin
    rstn = 1'b0;
    load = '0;
    fill_program();
    repeat (RESET_CYCLES) @(posedge clk);
    rstn <= 1'b1;
    @(negedge clk);
    mark = chk_err + main_err;
    assert (!inst_valid && !halt && pc == RESET_PC && fetch_count == 0 &&
            wait_mem_cycles == 0 && wait_down_cycles == 0) else begin
      $display("[ERROR] %0t: outputs or counters not cleared by reset", $time);
      main_err++;
    end
    load_program();
    drive_fetches(M_SEQ, 1);
    report_test("reset", 1, mark);

    mark = chk_err + main_err;
    drive_fetches(M_SEQ, SEQ_N);
    report_test("sequential", SEQ_N, mark);

    mark = chk_err + main_err;
    drive_fetches(M_JUMP, JUMP_N);
    report_test("jumps", JUMP_N, mark);

    mark = chk_err + main_err;
    base = stall_count;
    drive_fetches(M_STALL, STALL_N);
    assert (stall_count > base) else begin
      $display("back-pressure test never stalled the fetch unit");
      main_err++;
    end
    report_test("backpressure", STALL_N, mark);

    mark = chk_err + main_err;
    base = halt_expected;
    drive_fetches(M_HALT, HALT_N);
    mode = M_IDLE;
    @(negedge clk);
    assert (halt_expected > base) else begin
      $display("halt test never fetched the ebreak");
      main_err++;
    end
    assert (halt_seen == halt_expected && fetch_count == count_t'(hs_count)) else begin
      $display("[ERROR] %0t: halts %0d of %0d, fetch_count %0d of %0d", $time,
               halt_seen, halt_expected, fetch_count, hs_count);
      main_err++;
    end
    report_test("halt", HALT_N, mark);

    $display("tests 5, failed %0d, fetches %0d, errors %0d", failed_tests, hs_count,
             chk_err + main_err);
    if (chk_err + main_err == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

  initial begin
    repeat (TIMEOUT_CYC) @(posedge clk);
    $display("timeout: run stopped after %0d of %0d fetches", hs_count, TOTAL_N);
    $display("FAIL: see errors above");
    $finish;
  end

endmodule

// ==== flist.f ====
src/fetch_pkg.sv
src/ifu.sv
src/bank_router.sv
src/imem_bank.sv
src/resp_merge.sv
src/fetch_perf.sv
src/fetch_top.sv
verif/tb_fetch.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the fetch testbench with Verilator

cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert --top-module tb_fetch -f flist.f \
    -Mdir obj_dir -o tb_fetch \
  && ./obj_dir/tb_fetch | tee sim.log \
  || { echo "build or run of tb_fetch failed"; exit 1; }

grep -q "^PASS: all tests$" sim.log \
  && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }
